// ==== design/alu.sv ====
// execute stage alu
// add/sub/logic/slt result and branch condition
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [2:0] funct3,  // branch kind
  output word_t      result,
  output logic       bcond
);

  logic eq;
  logic lt;  // signed

  assign eq = (a == b);
  assign lt = ($signed(a) < $signed(b));

  always_comb begin
    case (op)
      alu_sub: result = a - b;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_xor: result = a ^ b;
      alu_slt: result = {31'b0, lt};
      default: result = a + b;  // alu_add, addresses
    endcase
  end

  always_comb begin
    case (funct3)
      f3_beq:  bcond = eq;
      f3_bne:  bcond = !eq;
      f3_blt:  bcond = lt;
      f3_bge:  bcond = !lt;
      default: bcond = 1'b0;  // unsigned kinds not supported
    endcase
  end

endmodule

// ==== design/cpu_core.sv ====
// five-stage RV32I pipeline core
// gshare fetch, EX resolve and redirect, MEM/WB forwarding, ecall halt
`timescale 1ns/1ps

module cpu_core import rv_isa_pkg::*, cpu_ctrl_pkg::*; #(
  parameter int HIST_BITS = 5
) (
  input  logic  clk,
  input  logic  reset,
  output word_t imem_addr,
  input  inst_t imem_data,
  output word_t dmem_addr,
  output word_t dmem_wdata,
  output logic  dmem_we,
  output logic  dmem_re,
  input  word_t dmem_rdata,
  output logic  halted
);

  word_t pc, pred_pc;
  logic [HIST_BITS-1:0] pred_hist, if_hist, ex_hist;
  inst_t if_inst;
  word_t if_pc;
  // decode outputs
  logic d_reg_write, d_mem_read, d_mem_write, d_alu_src, d_link;
  logic d_branch, d_jal, d_jalr, d_ecall;
  alu_op_t d_alu_op;
  word_t d_imm, rs1_data, rs2_data, ecall_val;
  reg_idx_t id_rs1, id_rs2;
  logic id_halt, stall_id, id_enter, halt_pend;
  // id/ex
  logic ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jal, ex_jalr, ex_halt;
  logic ex_link, ex_alu_src;
  alu_op_t ex_alu_op;
  word_t ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
  reg_idx_t ex_rd, ex_rs1, ex_rs2;
  logic [2:0] ex_funct3;
  // execute
  fwd_sel_t fwd_a, fwd_b;
  word_t op_a, op_b_reg, alu_result, ex_target, ex_next, ex_result;
  logic bcond, ex_taken, ex_ctrl, mispredict;
  // ex/mem and mem/wb
  logic mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;
  word_t mem_result, mem_store_data, mem_value, wb_value;
  reg_idx_t mem_rd, wb_rd;
  logic wb_reg_write, wb_halt, halt_seen;

  // operand mux for the ex stage
  function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                     word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset)
      pc <= '0;
    else if (mispredict)
      pc <= ex_next;                 // redirect from ex
    else if (!stall_id && !halt_pend)
      pc <= pred_pc;
  end

  gshare_btb #(.HIST_BITS(HIST_BITS)) btb_i (
    .clk(clk), .reset(reset), .pc(pc), .pred_pc(pred_pc), .hist(pred_hist),
    .upd_en(ex_ctrl), .upd_pc(ex_pc), .upd_taken(ex_taken),
    .upd_target(ex_target), .upd_hist(ex_hist)
  );

  always_ff @(posedge clk) begin
    if (reset || mispredict)
      if_inst <= '0;                 // opcode 0 decodes as no-op
    else if (!stall_id)
      if_inst <= imem_data;
  end

  always_ff @(posedge clk) begin
    if (!stall_id) begin
      if_pc   <= pc;
      if_hist <= pred_hist;
    end
  end

  instr_decoder dec_i (
    .inst(if_inst), .reg_write(d_reg_write), .mem_read(d_mem_read),
    .mem_write(d_mem_write), .alu_src(d_alu_src), .is_branch(d_branch),
    .is_jal(d_jal), .is_jalr(d_jalr), .link(d_link), .is_ecall(d_ecall),
    .alu_op(d_alu_op), .imm(d_imm)
  );

  assign id_rs1 = d_ecall ? halt_reg : if_inst[19:15];  // ecall reads a7
  assign id_rs2 = if_inst[24:20];

  register_file rf_i (
    .clk(clk), .reset(reset), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
    .rd_data(wb_value), .we(wb_reg_write), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  hazard_unit haz_i (
    .id_rs1(id_rs1), .id_rs2(id_rs2), .id_is_ecall(d_ecall),
    .ex_rd(ex_rd), .ex_mem_read(ex_mem_read), .ex_reg_write(ex_reg_write),
    .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .mem_rd(mem_rd), .mem_reg_write(mem_reg_write),
    .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
    .stall_id(stall_id), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  // a7 still in MEM is taken from there and WB goes through the rf bypass
  assign mem_value = mem_mem_read ? dmem_rdata : mem_result;
  assign ecall_val = (mem_reg_write && mem_rd == halt_reg) ? mem_value : rs1_data;
  assign id_halt   = d_ecall && ecall_val == halt_code;
  assign id_enter  = !stall_id && !mispredict && !halt_pend;  // else a bubble

  always_ff @(posedge clk) begin
    if (reset || !id_enter) begin
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch    <= 1'b0;
      ex_jal       <= 1'b0;
      ex_jalr      <= 1'b0;
      ex_halt      <= 1'b0;
    end else begin
      ex_reg_write <= d_reg_write;
      ex_mem_read  <= d_mem_read;
      ex_mem_write <= d_mem_write;
      ex_branch    <= d_branch;
      ex_jal       <= d_jal;
      ex_jalr      <= d_jalr;
      ex_halt      <= id_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc      <= if_pc;
    ex_hist    <= if_hist;
    ex_rs1_val <= rs1_data;
    ex_rs2_val <= rs2_data;
    ex_imm     <= d_imm;
    ex_rd      <= if_inst[11:7];
    ex_rs1     <= id_rs1;
    ex_rs2     <= id_rs2;
    ex_funct3  <= if_inst[14:12];
    ex_alu_op  <= d_alu_op;
    ex_alu_src <= d_alu_src;
    ex_link    <= d_link;
  end

  // nothing younger than a halting ecall gets past ID
  always_ff @(posedge clk) begin
    if (reset)
      halt_pend <= 1'b0;
    else if (id_enter && id_halt)
      halt_pend <= 1'b1;
  end

  assign op_a     = fwd_pick(fwd_a, ex_rs1_val, mem_result, wb_value);
  assign op_b_reg = fwd_pick(fwd_b, ex_rs2_val, mem_result, wb_value);  // also the store data

  alu alu_i (
    .op(ex_alu_op), .a(op_a), .b(ex_alu_src ? ex_imm : op_b_reg),
    .funct3(ex_funct3), .result(alu_result), .bcond(bcond)
  );

  assign ex_ctrl    = ex_branch || ex_jal || ex_jalr;
  assign ex_taken   = ex_jal || ex_jalr || (ex_branch && bcond);
  assign ex_target  = ex_jalr ? {alu_result[31:1], 1'b0} : ex_pc + ex_imm;
  assign ex_next    = ex_taken ? ex_target : ex_pc + 32'd4;
  assign mispredict = ex_ctrl && ex_next != if_pc;   // ID holds the fetched successor
  assign ex_result  = ex_link ? ex_pc + 32'd4 : alu_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_halt      <= 1'b0;
    end else begin
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_halt      <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_result     <= ex_result;
    mem_store_data <= op_b_reg;
    mem_rd         <= ex_rd;
  end

  assign dmem_addr  = mem_result;
  assign dmem_wdata = mem_store_data;
  assign dmem_we    = mem_mem_write;
  assign dmem_re    = mem_mem_read;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_reg_write <= 1'b0;
      wb_halt      <= 1'b0;
      halt_seen    <= 1'b0;
    end else begin
      wb_reg_write <= mem_reg_write;
      wb_halt      <= mem_halt;
      halt_seen    <= halt_seen || wb_halt;  // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    wb_value <= mem_value;
    wb_rd    <= mem_rd;
  end

  assign halted = wb_halt || halt_seen;

  a_dmem_excl: assert property (@(posedge clk) disable iff (reset) !(dmem_we && dmem_re))
    else $error("data memory read and write in the same cycle");
  a_halt_held: assert property (@(posedge clk) halted && !reset |=> halted)
    else $error("halted fell without reset");

endmodule

// ==== design/cpu_ctrl_pkg.sv ====
// internal control encodings of the pipeline
// alu ops, forwarding selects, predictor counters
package cpu_ctrl_pkg;

  typedef logic [2:0] alu_op_t;
  localparam alu_op_t alu_add = 3'd0;
  localparam alu_op_t alu_sub = 3'd1;
  localparam alu_op_t alu_and = 3'd2;
  localparam alu_op_t alu_or  = 3'd3;
  localparam alu_op_t alu_xor = 3'd4;
  localparam alu_op_t alu_slt = 3'd5;  // signed

  typedef logic [1:0] fwd_sel_t;  // ex operand source
  localparam fwd_sel_t fwd_none = 2'd0;  // id/ex copy
  localparam fwd_sel_t fwd_mem  = 2'd1;  // ex/mem result
  localparam fwd_sel_t fwd_wb   = 2'd2;  // mem/wb value

  typedef logic [1:0] ctr_t;  // saturating, msb set means taken
  localparam ctr_t ctr_weak_nt = 2'b01;

endpackage

// ==== design/gshare_btb.sv ====
// gshare branch predictor with target table
// pc xor history indexes counters, tags and targets
`timescale 1ns/1ps

module gshare_btb import rv_isa_pkg::*, cpu_ctrl_pkg::*; #(
  parameter int HIST_BITS = 5  // history and index width
) (
  input  logic                 clk,
  input  logic                 reset,
  input  word_t                pc,          // fetch pc
  output word_t                pred_pc,
  output logic [HIST_BITS-1:0] hist,        // snapshot for update
  input  logic                 upd_en,      // ex holds a transfer
  input  word_t                upd_pc,
  input  logic                 upd_taken,
  input  word_t                upd_target,
  input  logic [HIST_BITS-1:0] upd_hist
);

  localparam int ENTRIES = 1 << HIST_BITS;

  logic [HIST_BITS-1:0] ghr;     // resolved outcomes, newest in lsb
  logic [HIST_BITS-1:0] rd_idx;
  logic [HIST_BITS-1:0] wr_idx;
  logic                 valid  [ENTRIES];
  ctr_t                 ctr    [ENTRIES];
  word_t                tag    [ENTRIES];
  word_t                target [ENTRIES];
  logic                 hit;

  assign hist    = ghr;
  assign rd_idx  = pc[HIST_BITS+1:2] ^ ghr;
  assign wr_idx  = upd_pc[HIST_BITS+1:2] ^ upd_hist;  // same index as at fetch
  assign hit     = valid[rd_idx] && tag[rd_idx] == pc && ctr[rd_idx][1];
  assign pred_pc = hit ? target[rd_idx] : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      ghr <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        valid[i] <= 1'b0;
        ctr[i]   <= ctr_weak_nt;
      end
    end else if (upd_en) begin
      ghr            <= {ghr[HIST_BITS-2:0], upd_taken};
      valid[wr_idx]  <= 1'b1;
      if (upd_taken && ctr[wr_idx] != 2'b11)
        ctr[wr_idx] <= ctr[wr_idx] + 2'd1;
      else if (!upd_taken && ctr[wr_idx] != 2'b00)
        ctr[wr_idx] <= ctr[wr_idx] - 2'd1;
    end
  end

  // tag and target, meaningful only with valid
  always_ff @(posedge clk) begin
    if (upd_en) begin
      tag[wr_idx]    <= upd_pc;
      target[wr_idx] <= upd_target;
    end
  end

endmodule

// ==== design/hazard_unit.sv ====
// hazard detection and forwarding control
// ex operand selects plus load-use and ecall stalls
`timescale 1ns/1ps

module hazard_unit import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
  input  reg_idx_t id_rs1,       // x17 when ecall
  input  reg_idx_t id_rs2,
  input  logic     id_is_ecall,
  input  reg_idx_t ex_rd,
  input  logic     ex_mem_read,
  input  logic     ex_reg_write,
  input  reg_idx_t ex_rs1,
  input  reg_idx_t ex_rs2,
  input  reg_idx_t mem_rd,
  input  logic     mem_reg_write,
  input  reg_idx_t wb_rd,
  input  logic     wb_reg_write,
  output logic     stall_id,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b
);

  logic load_use;
  logic ecall_wait;

  // newest producer first and x0 never forwarded
  function automatic fwd_sel_t pick(reg_idx_t src, logic m_we, reg_idx_t m_rd,
                                    logic w_we, reg_idx_t w_rd);
    fwd_sel_t sel;
    sel = fwd_none;
    if (m_we && m_rd != '0 && m_rd == src)
      sel = fwd_mem;
    else if (w_we && w_rd != '0 && w_rd == src)
      sel = fwd_wb;
    return sel;
  endfunction

  assign fwd_a = pick(ex_rs1, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
  assign fwd_b = pick(ex_rs2, mem_reg_write, mem_rd, wb_reg_write, wb_rd);

  assign load_use   = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
  assign ecall_wait = id_is_ecall && ex_reg_write && ex_rd == halt_reg;  // x17 in flight
  assign stall_id   = load_use || ecall_wait;

endmodule

// ==== design/instr_decoder.sv ====
// instruction decoder for the ID stage
// control levels, alu op and sign-extended immediate
`timescale 1ns/1ps

module instr_decoder import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
  input  inst_t   inst,
  output logic    reg_write,
  output logic    mem_read,
  output logic    mem_write,
  output logic    alu_src,    // b operand is imm
  output logic    is_branch,
  output logic    is_jal,
  output logic    is_jalr,
  output logic    link,       // writes pc+4
  output logic    is_ecall,
  output alu_op_t alu_op,
  output word_t   imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       arith_ok;  // funct3 inside the subset
  alu_op_t    arith_op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // shared by r-type and i-type
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      f3_add:  arith_op = (opcode == op_rtype && inst[31:25] == funct7_alt) ? alu_sub : alu_add;
      f3_slt:  arith_op = alu_slt;
      f3_xor:  arith_op = alu_xor;
      f3_or:   arith_op = alu_or;
      f3_and:  arith_op = alu_and;
      default: begin
        arith_op = alu_add;
        arith_ok = 1'b0;  // shifts etc, dropped
      end
    endcase
  end

  always_comb begin
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    alu_src   = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    link      = 1'b0;
    is_ecall  = 1'b0;
    alu_op    = alu_add;                              // address sums
    imm       = {{20{inst[31]}}, inst[31:20]};        // i-type
    case (opcode)
      op_rtype: begin
        reg_write = arith_ok;
        alu_op    = arith_op;
      end
      op_itype: begin
        reg_write = arith_ok;
        alu_src   = 1'b1;
        alu_op    = arith_op;
      end
      op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        alu_src   = 1'b1;
      end
      op_store: begin
        mem_write = 1'b1;
        alu_src   = 1'b1;
        imm       = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      op_branch: begin
        is_branch = 1'b1;  // compare rs1 with rs2
        imm       = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      op_jal: begin
        is_jal    = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1;
        imm       = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      op_jalr: begin
        is_jalr   = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1;
        alu_src   = 1'b1;  // rs1 + imm
      end
      op_system: is_ecall = 1'b1;
      default: ;  // unknown, no-op
    endcase
  end

endmodule

// ==== design/register_file.sv ====
// 32 x 32 integer register file, x0 reads zero
// two async reads, one sync write with bypass
`timescale 1ns/1ps

module register_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  logic     we,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;  // x0 never written
    end
  end

  // same-cycle write wins over the stored value
  assign rs1_data = (we && rd != '0 && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (we && rd != '0 && rd == rs2) ? rd_data : regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

// ==== design/rv_isa_pkg.sv ====
// RV32I ISA definitions for the supported subset
// word types, opcodes and funct fields
package rv_isa_pkg;

  typedef logic [31:0] word_t;     // data or address
  typedef logic [31:0] inst_t;     // raw instruction
  typedef logic [4:0]  reg_idx_t;  // x0..x31

  // major opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;  // ecall only

  // funct3, alu kinds
  localparam logic [2:0] f3_add = 3'b000;  // add, sub, addi
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct3, branch kinds
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  localparam logic [6:0] funct7_alt = 7'b0100000;  // marks sub
  localparam word_t      halt_code  = 32'd10;      // a7 value that halts
  localparam reg_idx_t   halt_reg   = 5'd17;       // a7

endpackage

// ==== src.f ====
design/rv_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/hazard_unit.sv
design/gshare_btb.sv
design/cpu_core.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// ==== testbench/tb_clock.sv ====
// testbench clock source
// free-running, 8 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #4 clk = ~clk;  // half period

endmodule

// ==== testbench/tb_cpu.sv ====
// testbench for the five-stage pipeline core
// instruction and data memory models, program table, store checks
`timescale 1ns/1ps

module tb_cpu;

  localparam int n_tests       = 6;
  localparam int mem_words     = 64;
  localparam int settle_cycles = 8;  // catches stores after halt

  // rv32i encoding fields
  localparam logic [6:0] op_imm  = 7'b0010011;
  localparam logic [6:0] op_ld   = 7'b0000011;
  localparam logic [6:0] op_jr   = 7'b1100111;
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_sub  = 7'b0100000;
  localparam logic [2:0] f_add   = 3'b000;
  localparam logic [2:0] f_slt   = 3'b010;
  localparam logic [2:0] f_xor   = 3'b100;
  localparam logic [2:0] f_or    = 3'b110;
  localparam logic [2:0] f_and   = 3'b111;
  localparam logic [2:0] f_beq   = 3'b000;
  localparam logic [2:0] f_bne   = 3'b001;
  localparam logic [2:0] f_blt   = 3'b100;
  localparam logic [2:0] f_bge   = 3'b101;
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic        clk;
  logic        reset = 1'b1;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic        dmem_re;
  logic        halted;

  logic [31:0] imem [mem_words];
  logic [31:0] dmem [mem_words];
  logic [31:0] st_addr [8];  // recorded stores, in order
  logic [31:0] st_data [8];
  int          store_count;

  // test table
  string       test_name [n_tests];
  logic [31:0] prog      [n_tests][16];
  logic [31:0] exp_addr  [n_tests][4];
  logic [31:0] exp_data  [n_tests][4];
  int          exp_count [n_tests];
  int          budget    [n_tests];  // cycles per test
  int          cur;
  int          fill;
  int          cycles = 0;
  int          limit;

  tb_clock clk_gen (.clk(clk));

  cpu_core #(.HIST_BITS(5)) dut_i (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .halted(halted)
  );

  // combinational read ports, word addressed
  assign imem_data  = reset ? 32'h0 : imem[imem_addr[7:2]];
  assign dmem_rdata = (reset || dmem_re !== 1'b1) ? 32'h0 : dmem[dmem_addr[7:2]];

  // data memory write port and store log, cleared by reset
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < mem_words; i++)
        dmem[i] <= 32'h0;
      store_count <= 0;
    end else if (dmem_we === 1'b1) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
      if (store_count < 8) begin
        st_addr[store_count] <= dmem_addr;
        st_data[store_count] <= dmem_wdata;
      end
      store_count <= store_count + 1;
    end
  end

  // run limit over all tests
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("core never halted before the cycle limit of %0d", limit);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input int rs1,
                                         input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_word(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return i_word(op_imm, f_add, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  task automatic new_entry(input string name, input int run_cycles);
    int i;
    cur = cur + 1;
    fill = 0;
    test_name[cur] = name;
    budget[cur]    = run_cycles;
    exp_count[cur] = 0;
    for (i = 0; i < 16; i++)
      prog[cur][i] = 32'h0;  // opcode 0, no-op
  endtask

  task automatic put(input logic [31:0] word);
    prog[cur][fill] = word;
    fill = fill + 1;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[cur][exp_count[cur]] = addr;
    exp_data[cur][exp_count[cur]] = data;
    exp_count[cur] = exp_count[cur] + 1;
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", what, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    cur = -1;
    new_entry("alu forwarding", 60);
    put(addi(1, 0, -3));
    put(addi(2, 0, 12));
    put(r_word(f7_base, f_add, 3, 1, 2));  // 9, wb and mem forward
    put(r_word(f7_sub, f_add, 4, 3, 1));   // 12
    put(r_word(f7_base, f_and, 5, 4, 3));  // 8
    put(r_word(f7_base, f_or, 6, 5, 1));   // fffffffd
    put(r_word(f7_base, f_xor, 7, 6, 2));  // fffffff1
    put(i_word(op_imm, f_and, 9, 7, 'h7f));
    put(r_word(f7_base, f_slt, 8, 1, 2));  // -3 < 12
    put(sw(3, 0, 0));
    put(sw(4, 0, 4));
    put(sw(9, 0, 8));
    put(sw(8, 0, 12));                     // store data from mem stage
    put(addi(17, 0, 10));
    put(ecall_word);
    expect_store(0, 32'd9);
    expect_store(4, 32'd12);
    expect_store(8, 32'h71);
    expect_store(12, 32'd1);

    new_entry("load use", 50);
    put(addi(1, 0, 'h123));
    put(sw(1, 0, 16));
    put(i_word(op_ld, 3'b010, 2, 0, 16));
    put(addi(3, 2, 'h10));                 // one bubble expected
    put(sw(3, 0, 20));
    put(i_word(op_ld, 3'b010, 4, 0, 20));
    put(sw(4, 0, 24));                     // loaded value as store data
    put(addi(17, 0, 10));
    put(ecall_word);
    expect_store(16, 32'h123);
    expect_store(20, 32'h133);
    expect_store(24, 32'h133);

    new_entry("counted loop", 120);
    put(addi(1, 0, 0));                    // count
    put(addi(2, 0, 8));                    // limit
    put(addi(3, 0, 0));                    // sum
    put(addi(1, 1, 1));                    // loop head, pc 12
    put(r_word(f7_base, f_add, 3, 3, 1));
    put(b_word(f_bne, 1, 2, -8));
    put(i_word(op_imm, f_slt, 4, 3, 40));
    put(i_word(op_imm, f_or, 5, 1, 'h30));
    put(sw(1, 0, 0));
    put(sw(3, 0, 4));
    put(sw(4, 0, 8));
    put(sw(5, 0, 12));
    put(addi(17, 0, 10));
    put(ecall_word);
    expect_store(0, 32'd8);
    expect_store(4, 32'd36);               // 1 + 2 + .. + 8
    expect_store(8, 32'd1);
    expect_store(12, 32'h38);

    new_entry("branch paths", 80);
    put(addi(1, 0, 1));
    put(addi(2, 0, -2));
    put(b_word(f_beq, 1, 2, 8));           // not taken
    put(addi(5, 0, 1));
    put(b_word(f_blt, 2, 1, 8));           // taken, skips next
    put(addi(5, 5, 64));
    put(b_word(f_bge, 2, 1, 8));           // not taken
    put(addi(5, 5, 2));
    put(b_word(f_bge, 1, 2, 20));          // taken to pc 52
    put(addi(5, 5, 4));                    // pc 36, via backward beq
    put(sw(5, 0, 0));
    put(addi(17, 0, 10));
    put(ecall_word);
    put(sw(5, 0, 4));                      // pc 52
    put(b_word(f_blt, 0, 2, -20));         // backward, not taken
    put(b_word(f_beq, 2, 2, -24));         // backward, taken to pc 36
    expect_store(4, 32'd3);
    expect_store(0, 32'd7);

    new_entry("jumps", 70);
    put(j_word(1, 12));                    // to pc 12, x1 = 4
    put(addi(5, 0, 99));
    put(sw(5, 0, 12));
    put(sw(1, 0, 0));
    put(addi(6, 0, 32));
    put(i_word(op_jr, 3'b000, 7, 6, 4));   // x6 + 4 = 36, x7 = 24
    put(sw(6, 0, 8));
    put(addi(17, 0, 10));
    put(ecall_word);
    put(sw(7, 0, 4));                      // pc 36
    put(j_word(9, 8));                     // to pc 48, x9 = 44
    put(sw(1, 0, 8));
    put(sw(9, 0, 8));
    put(addi(17, 0, 10));
    put(ecall_word);
    expect_store(0, 32'd4);
    expect_store(4, 32'd24);
    expect_store(8, 32'd44);

    new_entry("ecall halt", 50);
    put(addi(17, 0, 3));
    put(ecall_word);                       // x17 != 10, no-op
    put(i_word(op_imm, f_xor, 1, 0, 'h2a));
    put(sw(1, 0, 0));
    put(addi(17, 0, 10));
    put(ecall_word);                       // halts here
    put(sw(1, 0, 4));
    put(addi(2, 0, 5));
    put(sw(2, 0, 8));
    expect_store(0, 32'h2a);
  endtask

  task automatic run_test(input int t);
    int i;
    @(posedge clk);
    reset <= 1'b1;
    for (i = 0; i < mem_words; i++)
      imem[i] <= (i < 16) ? prog[t][i] : 32'h0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    compare_value({test_name[t], " halted after reset"}, 32'h0, {31'h0, halted});
    while (halted !== 1'b1)
      @(posedge clk);
    repeat (settle_cycles) @(posedge clk);
    compare_value({test_name[t], " store count"}, exp_count[t], store_count);
    for (i = 0; i < exp_count[t]; i++) begin
      compare_value($sformatf("%s store %0d addr", test_name[t], i),
                    exp_addr[t][i], st_addr[i]);
      compare_value($sformatf("%s store %0d data", test_name[t], i),
                    exp_data[t][i], st_data[i]);
    end
  endtask

  initial begin
    int t;
    for (t = 0; t < mem_words; t++)
      imem[t] = 32'h0;
    build_table();
    limit = 0;
    for (t = 0; t < n_tests; t++)
      limit += budget[t] + 16;   // run budget plus reset hold
    for (t = 0; t < n_tests; t++)
      run_test(t);
    $display("TB PASSED");
    $finish;
  end

endmodule
